//--- list.f
+incdir+logic
logic/streamer_pkg.sv
logic/mem_if.sv
logic/hci_fifo.sv
logic/stream_source.sv
logic/stream_sink.sv
logic/mem_arbiter.sv
logic/streamer_top.sv
testbench/tb_streamer.sv

//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_streamer
FLIST  = list.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/tb_streamer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_streamer;

  localparam int unsigned SEED    = 32'h72a50b29;
  localparam int          TIMEOUT = 5000;
  // Reads a source may have in flight plus buffered
  localparam int          MAX_OUT = 4;

  logic                       clk;
  logic                       arst_n_i;
  logic                       clear_i;
  logic                       enable_i;
  streamer_pkg::stream_ctrl_t x_ctrl_i;
  streamer_pkg::stream_ctrl_t w_ctrl_i;
  streamer_pkg::stream_ctrl_t z_ctrl_i;
  logic                       x_valid_o;
  logic                       x_ready_i;
  streamer_pkg::word_t        x_data_o;
  logic                       w_valid_o;
  logic                       w_ready_i;
  streamer_pkg::word_t        w_data_o;
  logic                       z_valid_i;
  logic                       z_ready_o;
  streamer_pkg::word_t        z_data_i;
  logic                       x_done_o;
  logic                       w_done_o;
  logic                       z_done_o;
  logic                       mem_req_o;
  logic                       mem_gnt_i;
  streamer_pkg::addr_t        mem_add_o;
  logic                       mem_wen_o;
  streamer_pkg::word_t        mem_data_o;
  streamer_pkg::word_t        mem_r_data_i;
  logic                       mem_r_valid_i;

  // Sparse memory, unwritten words come from the fill pattern
  streamer_pkg::word_t mem_model [streamer_pkg::addr_t];
  logic                rsp_pending;
  streamer_pkg::word_t rsp_data;
  // Expected beats and writes, in order
  streamer_pkg::word_t x_exp [$];
  streamer_pkg::word_t w_exp [$];
  streamer_pkg::addr_t z_exp_add [$];
  streamer_pkg::word_t z_exp_data [$];
  // Z words still to be offered on the stream
  streamer_pkg::word_t z_words [$];
  logic                z_fired;
  int                  done_cnt [3];
  // Granted X reads minus X beats
  int                  x_out;
  // Handshake probabilities in percent
  int                  gnt_pct;
  int                  x_ready_pct;
  int                  w_ready_pct;
  int                  z_valid_pct;

  streamer_top streamer_top_inst (
    .clk_i         ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .clear_i       ( clear_i       ),
    .enable_i      ( enable_i      ),
    .x_ctrl_i      ( x_ctrl_i      ),
    .w_ctrl_i      ( w_ctrl_i      ),
    .z_ctrl_i      ( z_ctrl_i      ),
    .x_valid_o     ( x_valid_o     ),
    .x_ready_i     ( x_ready_i     ),
    .x_data_o      ( x_data_o      ),
    .w_valid_o     ( w_valid_o     ),
    .w_ready_i     ( w_ready_i     ),
    .w_data_o      ( w_data_o      ),
    .z_valid_i     ( z_valid_i     ),
    .z_ready_o     ( z_ready_o     ),
    .z_data_i      ( z_data_i      ),
    .x_done_o      ( x_done_o      ),
    .w_done_o      ( w_done_o      ),
    .z_done_o      ( z_done_o      ),
    .mem_req_o     ( mem_req_o     ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_add_o     ( mem_add_o     ),
    .mem_wen_o     ( mem_wen_o     ),
    .mem_data_o    ( mem_data_o    ),
    .mem_r_data_i  ( mem_r_data_i  ),
    .mem_r_valid_i ( mem_r_valid_i )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Preload pattern, every address bit matters
  function automatic streamer_pkg::word_t fill_word(input streamer_pkg::addr_t a);
    return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'hc3a5_9e17;
  endfunction

  function automatic streamer_pkg::word_t read_word(input streamer_pkg::addr_t a);
    if (mem_model.exists(a)) begin
      return mem_model[a];
    end
    return fill_word(a);
  endfunction

  // Word a load job must deliver at position idx
  function automatic streamer_pkg::word_t ref_load(input streamer_pkg::addr_t base,
                                                   input streamer_pkg::addr_t stride,
                                                   input int idx);
    return fill_word(base + streamer_pkg::addr_t'(idx) * stride);
  endfunction

  task automatic report_failure();
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    report_failure();
  endtask

  task automatic check_word(input string what, input streamer_pkg::word_t got,
                            input streamer_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_addr(input string what, input streamer_pkg::addr_t got,
                            input streamer_pkg::addr_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      report_failure();
    end
  endtask

  // Memory side, stream beats, writes and done flags
  always @(posedge clk) begin
    if (arst_n_i && !clear_i) begin
      if (mem_req_o && mem_gnt_i) begin
        if (mem_wen_o) begin
          check_flag("write was expected", z_exp_add.size() > 0, 1'b1);
          check_addr("z write address", mem_add_o, z_exp_add.pop_front());
          check_word("z write data", mem_data_o, z_exp_data.pop_front());
          mem_model[mem_add_o] = mem_data_o;
        end else begin
          // Answered on the next cycle
          rsp_pending = 1'b1;
          rsp_data    = read_word(mem_add_o);
          if (mem_add_o[31:28] == 4'h1) begin
            x_out++;
          end
        end
      end
      if (x_valid_o && x_ready_i) begin
        check_flag("x beat was expected", x_exp.size() > 0, 1'b1);
        check_word("x beat", x_data_o, x_exp.pop_front());
        x_out--;
      end
      if (w_valid_o && w_ready_i) begin
        check_flag("w beat was expected", w_exp.size() > 0, 1'b1);
        check_word("w beat", w_data_o, w_exp.pop_front());
      end
      if (z_valid_i && z_ready_o) begin
        void'(z_words.pop_front());
        z_fired = 1'b1;
      end
      check_flag("x outstanding reads within limit", x_out <= MAX_OUT, 1'b1);
      if (x_done_o) begin
        done_cnt[0]++;
        check_flag("x done after its last beat", x_exp.size() == 0, 1'b1);
      end
      if (w_done_o) begin
        done_cnt[1]++;
        check_flag("w done after its last beat", w_exp.size() == 0, 1'b1);
      end
      if (z_done_o) begin
        done_cnt[2]++;
        check_flag("z done after its last write", z_exp_add.size() == 0, 1'b1);
      end
    end
  end

  // Random grant and ready, read responses, Z stream driver
  always @(negedge clk) begin
    if (arst_n_i) begin
      mem_gnt_i     = ($urandom % 100) < gnt_pct;
      x_ready_i     = ($urandom % 100) < x_ready_pct;
      w_ready_i     = ($urandom % 100) < w_ready_pct;
      mem_r_valid_i = rsp_pending;
      mem_r_data_i  = rsp_pending ? rsp_data : '0;
      rsp_pending   = 1'b0;
      // A raised beat holds until taken
      if (!z_valid_i || z_fired) begin
        z_valid_i = (z_words.size() > 0) && (($urandom % 100) < z_valid_pct);
        z_data_i  = (z_words.size() > 0) ? z_words[0] : '0;
      end
      z_fired = 1'b0;
    end
  end

  // ch 0 is X, ch 1 is W
  task automatic start_load(input int ch, input int count);
    streamer_pkg::stream_ctrl_t job;
    job.start  = 1'b1;
    job.base   = streamer_pkg::addr_t'((ch == 0 ? 32'h1000_0000 : 32'h2000_0000) +
                                       ($urandom % 1024) * 4);
    job.stride = streamer_pkg::addr_t'((($urandom % 8) + 1) * 4);
    job.count  = 16'(count);
    done_cnt[ch] = 0;
    for (int i = 0; i < count; i++) begin
      if (ch == 0) x_exp.push_back(ref_load(job.base, job.stride, i));
      else w_exp.push_back(ref_load(job.base, job.stride, i));
    end
    @(negedge clk);
    if (ch == 0) x_ctrl_i = job;
    else w_ctrl_i = job;
    @(negedge clk);
    x_ctrl_i.start = 1'b0;
    w_ctrl_i.start = 1'b0;
  endtask

  task automatic start_store(input int count);
    streamer_pkg::stream_ctrl_t job;
    streamer_pkg::word_t        data;
    job.start  = 1'b1;
    job.base   = streamer_pkg::addr_t'(32'h3000_0000 + ($urandom % 1024) * 4);
    job.stride = streamer_pkg::addr_t'((($urandom % 8) + 1) * 4);
    job.count  = 16'(count);
    done_cnt[2] = 0;
    for (int i = 0; i < count; i++) begin
      data = $urandom;
      z_words.push_back(data);
      z_exp_add.push_back(job.base + streamer_pkg::addr_t'(i) * job.stride);
      z_exp_data.push_back(data);
    end
    @(negedge clk);
    z_ctrl_i = job;
    @(negedge clk);
    z_ctrl_i.start = 1'b0;
  endtask

  task automatic wait_done(input int ch, input string name);
    int cycles;
    cycles = 0;
    while (done_cnt[ch] == 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) timeout_fail(name);
    end
    // Flag must not pulse again
    repeat (4) @(negedge clk);
    check_flag("single done pulse", done_cnt[ch] == 1, 1'b1);
  endtask

  // Nothing may move while no job runs
  task automatic check_quiet(input int n);
    repeat (n) begin
      @(posedge clk);
      check_flag("memory request", mem_req_o, 1'b0);
      check_flag("x valid", x_valid_o, 1'b0);
      check_flag("w valid", w_valid_o, 1'b0);
      check_flag("z ready", z_ready_o, 1'b0);
      check_flag("any done flag", x_done_o | w_done_o | z_done_o, 1'b0);
    end
  endtask

  initial begin
    int cycles;
    void'($urandom(SEED));
    arst_n_i      = 1'b0;
    clear_i       = 1'b0;
    enable_i      = 1'b1;
    x_ctrl_i      = '0;
    w_ctrl_i      = '0;
    z_ctrl_i      = '0;
    x_ready_i     = 1'b0;
    w_ready_i     = 1'b0;
    z_valid_i     = 1'b0;
    z_data_i      = '0;
    mem_gnt_i     = 1'b0;
    mem_r_data_i  = '0;
    mem_r_valid_i = 1'b0;
    rsp_pending   = 1'b0;
    rsp_data      = '0;
    z_fired       = 1'b0;
    x_out         = 0;
    done_cnt      = '{0, 0, 0};
    gnt_pct       = 70;
    x_ready_pct   = 100;
    w_ready_pct   = 100;
    z_valid_pct   = 100;
    repeat (4) @(negedge clk);
    arst_n_i = 1'b1;

    // Idle after reset
    check_quiet(20);

    // Single X job
    start_load(0, int'($urandom % 20) + 4);
    wait_done(0, "the x done flag");

    // X and W together under random handshakes
    gnt_pct     = 50;
    x_ready_pct = 60;
    w_ready_pct = 60;
    start_load(0, int'($urandom % 20) + 4);
    start_load(1, int'($urandom % 20) + 4);
    wait_done(0, "the x done flag");
    wait_done(1, "the w done flag");

    // Z store job
    gnt_pct     = 60;
    z_valid_pct = 70;
    start_store(int'($urandom % 20) + 4);
    wait_done(2, "the z done flag");

    // All three, X stalled by its consumer
    x_ready_pct = 0;
    w_ready_pct = 80;
    z_valid_pct = 80;
    start_load(0, 16);
    start_load(1, int'($urandom % 20) + 4);
    start_store(int'($urandom % 20) + 4);
    wait_done(1, "the w done flag");
    wait_done(2, "the z done flag");
    repeat (100) @(negedge clk);
    // Stalled X fills its whole buffer credit and no more
    check_flag("x reads up to its buffer depth", x_out == MAX_OUT, 1'b1);
    x_ready_pct = 100;
    wait_done(0, "the x done flag");

    // Clear in the middle of an X job
    gnt_pct = 50;
    start_load(0, 24);
    cycles = 0;
    while (x_exp.size() > 16) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) timeout_fail("x beats before the clear");
    end
    clear_i = 1'b1;
    x_exp.delete();
    x_out = 0;
    repeat (2) @(negedge clk);
    clear_i = 1'b0;
    check_quiet(10);
    start_load(0, int'($urandom % 20) + 4);
    wait_done(0, "the x done flag after the clear");

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/streamer_top.sv
`include "streamer_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module streamer_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       enable_i,
  input  streamer_pkg::stream_ctrl_t x_ctrl_i,
  input  streamer_pkg::stream_ctrl_t w_ctrl_i,
  input  streamer_pkg::stream_ctrl_t z_ctrl_i,
  output logic                       x_valid_o,
  input  logic                       x_ready_i,
  output streamer_pkg::word_t        x_data_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  output streamer_pkg::word_t        w_data_o,
  input  logic                       z_valid_i,
  output logic                       z_ready_o,
  input  streamer_pkg::word_t        z_data_i,
  output logic                       x_done_o,
  output logic                       w_done_o,
  output logic                       z_done_o,
  output logic                       mem_req_o,
  input  logic                       mem_gnt_i,
  output streamer_pkg::addr_t        mem_add_o,
  output logic                       mem_wen_o,
  output streamer_pkg::word_t        mem_data_o,
  input  streamer_pkg::word_t        mem_r_data_i,
  input  logic                       mem_r_valid_i
);

  // Channel buses: 0 is X, 1 is W, 2 is Z
  mem_if ch_bus [`STREAMER_NCH] ();

  // X load channel
  stream_source x_source_inst (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .clear_i  ( clear_i   ),
    .enable_i ( enable_i  ),
    .ctrl_i   ( x_ctrl_i  ),
    .mem      ( ch_bus[0] ),
    .valid_o  ( x_valid_o ),
    .ready_i  ( x_ready_i ),
    .data_o   ( x_data_o  ),
    .done_o   ( x_done_o  )
  );

  // W load channel
  stream_source w_source_inst (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .clear_i  ( clear_i   ),
    .enable_i ( enable_i  ),
    .ctrl_i   ( w_ctrl_i  ),
    .mem      ( ch_bus[1] ),
    .valid_o  ( w_valid_o ),
    .ready_i  ( w_ready_i ),
    .data_o   ( w_data_o  ),
    .done_o   ( w_done_o  )
  );

  // Z store channel
  stream_sink z_sink_inst (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .clear_i  ( clear_i   ),
    .enable_i ( enable_i  ),
    .ctrl_i   ( z_ctrl_i  ),
    .valid_i  ( z_valid_i ),
    .ready_o  ( z_ready_o ),
    .data_i   ( z_data_i  ),
    .mem      ( ch_bus[2] ),
    .done_o   ( z_done_o  )
  );

  // Shared memory port
  mem_arbiter arbiter_inst (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .clear_i       ( clear_i       ),
    .ch            ( ch_bus        ),
    .mem_req_o     ( mem_req_o     ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_add_o     ( mem_add_o     ),
    .mem_wen_o     ( mem_wen_o     ),
    .mem_data_o    ( mem_data_o    ),
    .mem_r_data_i  ( mem_r_data_i  ),
    .mem_r_valid_i ( mem_r_valid_i )
  );

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`include "streamer_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clear_i,
  mem_if.target               ch [`STREAMER_NCH],
  output logic                mem_req_o,
  input  logic                mem_gnt_i,
  output streamer_pkg::addr_t mem_add_o,
  output logic                mem_wen_o,
  output streamer_pkg::word_t mem_data_o,
  input  streamer_pkg::word_t mem_r_data_i,
  input  logic                mem_r_valid_i
);

  logic [`STREAMER_NCH-1:0] req_v;
  logic [`STREAMER_NCH-1:0] wen_v;
  logic [`STREAMER_NCH-1:0] gnt_v;
  streamer_pkg::addr_t      add_v [`STREAMER_NCH];
  streamer_pkg::word_t      data_v [`STREAMER_NCH];
  streamer_pkg::ch_id_t     last_q;
  streamer_pkg::ch_id_t     win;
  streamer_pkg::ch_id_t     rsp_id;
  logic                     found;
  logic                     granted;
  logic                     id_full;
  logic                     id_empty;

  // Flatten the channel buses, route grant and response back
  for (genvar i = 0; i < `STREAMER_NCH; i++) begin : gen_ch
    assign req_v[i]      = ch[i].req;
    assign wen_v[i]      = ch[i].wen;
    assign add_v[i]      = ch[i].add;
    assign data_v[i]     = ch[i].data;
    assign gnt_v[i]      = granted && (win == streamer_pkg::ch_id_t'(i));
    assign ch[i].gnt     = gnt_v[i];
    assign ch[i].r_data  = mem_r_data_i;
    assign ch[i].r_valid = mem_r_valid_i && (rsp_id == streamer_pkg::ch_id_t'(i));
  end

  // Round robin, search starts just after the last winner
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    win   = last_q;
    for (int unsigned k = 1; k <= `STREAMER_NCH; k++) begin
      idx = (int'(last_q) + k) % `STREAMER_NCH;
      if (!found && req_v[idx]) begin
        found = 1'b1;
        win   = streamer_pkg::ch_id_t'(idx);
      end
    end
  end

  // No grant during clear, so no response outlives the ID buffer
  // Reads also wait while the ID buffer is full
  assign mem_req_o  = found && !clear_i && !(id_full && !wen_v[win]);
  assign mem_add_o  = add_v[win];
  assign mem_wen_o  = wen_v[win];
  assign mem_data_o = data_v[win];
  assign granted    = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= streamer_pkg::ch_id_t'(`STREAMER_NCH - 1);
    end else if (clear_i) begin
      last_q <= streamer_pkg::ch_id_t'(`STREAMER_NCH - 1);
    end else if (granted) begin
      last_q <= win;
    end
  end

  // Owner of each granted read, popped as its response returns
  hci_fifo #(
    .payload_t ( streamer_pkg::ch_id_t ),
    .DEPTH     ( `STREAMER_NCH         )
  ) id_fifo_inst (
    .clk_i    ( clk_i                  ),
    .arst_n_i ( arst_n_i               ),
    .clear_i  ( clear_i                ),
    .push_i   ( granted && !mem_wen_o  ),
    .data_i   ( win                    ),
    .full_o   ( id_full                ),
    .pop_i    ( mem_r_valid_i          ),
    .data_o   ( rsp_id                 ),
    .empty_o  ( id_empty               )
  );

  // Memory answers a granted read exactly one cycle later
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_r_valid_i |-> $past(granted && !mem_wen_o));
  // Memory answers only reads it has granted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_r_valid_i |-> !id_empty);

endmodule

`default_nettype wire

//--- logic/stream_sink.sv
`include "streamer_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module stream_sink (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       enable_i,
  input  streamer_pkg::stream_ctrl_t ctrl_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  input  streamer_pkg::word_t        data_i,
  mem_if.initiator                   mem,
  output logic                       done_o
);

  logic                       active_q;
  logic                       req_hold_q;
  logic                       done_q;
  logic [`STREAMER_CNT_W-1:0] total_q;
  logic [`STREAMER_CNT_W-1:0] accepted_q;
  logic [`STREAMER_CNT_W-1:0] written_q;
  streamer_pkg::addr_t        addr_q;
  streamer_pkg::addr_t        stride_q;
  streamer_pkg::store_req_t   wr_entry;
  streamer_pkg::store_req_t   head;
  logic                       accept;
  logic                       wr_fire;
  logic                       last_write;
  logic                       buf_full;
  logic                       buf_empty;

  // Stop taking beats once count is reached or the buffer fills
  assign ready_o       = active_q && enable_i && !buf_full && (accepted_q != total_q);
  assign accept        = valid_i && ready_o;
  // Each beat is paired with the next strided address
  assign wr_entry.add  = addr_q;
  assign wr_entry.data = data_i;

  // Drain side, request held until granted
  assign mem.req    = !buf_empty && (enable_i || req_hold_q);
  assign mem.add    = head.add;
  assign mem.wen    = 1'b1;
  assign mem.data   = head.data;
  assign wr_fire    = mem.req && mem.gnt;
  assign last_write = wr_fire && (written_q == total_q - 1'b1);
  assign done_o     = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      req_hold_q <= 1'b0;
      done_q     <= 1'b0;
      total_q    <= '0;
      accepted_q <= '0;
      written_q  <= '0;
      addr_q     <= '0;
      stride_q   <= '0;
    end else if (clear_i) begin
      active_q   <= 1'b0;
      req_hold_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      req_hold_q <= mem.req && !mem.gnt;
      done_q     <= last_write;
      if (!active_q) begin
        if (ctrl_i.start && (ctrl_i.count != '0)) begin
          active_q   <= 1'b1;
          addr_q     <= ctrl_i.base;
          stride_q   <= ctrl_i.stride;
          total_q    <= ctrl_i.count;
          accepted_q <= '0;
          written_q  <= '0;
        end
      end else begin
        if (accept) begin
          addr_q     <= addr_q + stride_q;
          accepted_q <= accepted_q + 1'b1;
        end
        if (wr_fire) begin
          written_q <= written_q + 1'b1;
        end
        // Job ends with its last granted write
        if (last_write) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // Store buffer between the stream and the write port
  hci_fifo #(
    .payload_t ( streamer_pkg::store_req_t ),
    .DEPTH     ( `STREAMER_STORE_DEPTH     )
  ) store_fifo_inst (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .clear_i  ( clear_i   ),
    .push_i   ( accept    ),
    .data_i   ( wr_entry  ),
    .full_o   ( buf_full  ),
    .pop_i    ( wr_fire   ),
    .data_o   ( head      ),
    .empty_o  ( buf_empty )
  );

endmodule

`default_nettype wire

//--- logic/stream_source.sv
`include "streamer_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module stream_source (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       enable_i,
  input  streamer_pkg::stream_ctrl_t ctrl_i,
  mem_if.initiator                   mem,
  output logic                       valid_o,
  input  logic                       ready_i,
  output streamer_pkg::word_t        data_o,
  output logic                       done_o
);

  localparam int unsigned PEND_W = $clog2(`STREAMER_LOAD_DEPTH + 1);

  logic                       active_q;
  logic                       req_hold_q;
  logic                       valid_hold_q;
  logic                       done_q;
  logic [`STREAMER_CNT_W-1:0] total_q;
  logic [`STREAMER_CNT_W-1:0] issued_q;
  logic [`STREAMER_CNT_W-1:0] delivered_q;
  streamer_pkg::addr_t        addr_q;
  streamer_pkg::addr_t        stride_q;
  // Reads in flight plus words waiting in the buffer
  logic [PEND_W-1:0]          pending_q;
  logic                       can_issue;
  logic                       rd_fire;
  logic                       beat;
  logic                       last_beat;
  logic                       buf_full;
  logic                       buf_empty;

  // Credit check keeps every response a free buffer slot
  assign can_issue = active_q && (issued_q != total_q) &&
                     (pending_q < PEND_W'(`STREAMER_LOAD_DEPTH));
  // A raised request stays up until granted, even with enable low
  assign mem.req   = can_issue && (enable_i || req_hold_q);
  assign mem.add   = addr_q;
  assign mem.wen   = 1'b0;
  assign mem.data  = '0;
  assign rd_fire   = mem.req && mem.gnt;

  // Same hold rule for the outgoing stream
  assign valid_o   = !buf_empty && (enable_i || valid_hold_q);
  assign beat      = valid_o && ready_i;
  assign last_beat = beat && (delivered_q == total_q - 1'b1);
  assign done_o    = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q     <= 1'b0;
      req_hold_q   <= 1'b0;
      valid_hold_q <= 1'b0;
      done_q       <= 1'b0;
      pending_q    <= '0;
      total_q      <= '0;
      issued_q     <= '0;
      delivered_q  <= '0;
      addr_q       <= '0;
      stride_q     <= '0;
    end else if (clear_i) begin
      active_q     <= 1'b0;
      req_hold_q   <= 1'b0;
      valid_hold_q <= 1'b0;
      done_q       <= 1'b0;
      pending_q    <= '0;
    end else begin
      req_hold_q   <= mem.req && !mem.gnt;
      valid_hold_q <= valid_o && !ready_i;
      done_q       <= last_beat;
      pending_q    <= pending_q + PEND_W'(rd_fire) - PEND_W'(beat);
      if (!active_q) begin
        // New job is taken only while idle, empty jobs are ignored
        if (ctrl_i.start && (ctrl_i.count != '0)) begin
          active_q    <= 1'b1;
          addr_q      <= ctrl_i.base;
          stride_q    <= ctrl_i.stride;
          total_q     <= ctrl_i.count;
          issued_q    <= '0;
          delivered_q <= '0;
        end
      end else begin
        if (rd_fire) begin
          addr_q   <= addr_q + stride_q;
          issued_q <= issued_q + 1'b1;
        end
        if (beat) begin
          delivered_q <= delivered_q + 1'b1;
        end
        if (last_beat) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // Load buffer, filled by routed read responses
  hci_fifo #(
    .payload_t ( streamer_pkg::word_t  ),
    .DEPTH     ( `STREAMER_LOAD_DEPTH  )
  ) load_fifo_inst (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .clear_i  ( clear_i     ),
    .push_i   ( mem.r_valid ),
    .data_i   ( mem.r_data  ),
    .full_o   ( buf_full    ),
    .pop_i    ( beat        ),
    .data_o   ( data_o      ),
    .empty_o  ( buf_empty   )
  );

  // Issued but undelivered words never exceed the buffer depth
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    active_q |-> int'(issued_q - delivered_q) <= `STREAMER_LOAD_DEPTH);
  // Arbiter routes a response here only when a slot is free
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem.r_valid |-> !buf_full);

endmodule

`default_nettype wire

//--- logic/hci_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module hci_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     clear_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // Overflow and underflow are dropped here and flagged below
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  // Head entry, valid the cycle after its push
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Producers must respect full, consumers must respect empty
  assert property (@(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!arst_n_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- logic/mem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_if;

  // Request side, held until req and gnt meet
  logic                req;
  logic                gnt;
  streamer_pkg::addr_t add;
  // High for a write
  logic                wen;
  streamer_pkg::word_t data;

  // Read response, one per granted read, in grant order
  streamer_pkg::word_t r_data;
  logic                r_valid;

  modport initiator (
    output req, add, wen, data,
    input  gnt, r_data, r_valid
  );

  modport target (
    input  req, add, wen, data,
    output gnt, r_data, r_valid
  );

endinterface

`default_nettype wire

//--- logic/streamer_pkg.sv
`include "streamer_defines.svh"

`default_nettype none

package streamer_pkg;

  // One memory or stream word
  typedef logic [`STREAMER_DW-1:0] word_t;

  // Byte address
  typedef logic [`STREAMER_AW-1:0] addr_t;

  // Job for one channel, start is a single-cycle pulse
  typedef struct packed {
    logic                       start;
    addr_t                      base;
    addr_t                      stride;
    logic [`STREAMER_CNT_W-1:0] count;
  } stream_ctrl_t;

  // Store buffer entry, target address with its word
  typedef struct packed {
    addr_t add;
    word_t data;
  } store_req_t;

  // Arbiter port index: 0 is X, 1 is W, 2 is Z
  typedef logic [1:0] ch_id_t;

endpackage

`default_nettype wire

//--- logic/streamer_defines.svh
`ifndef STREAMER_DEFINES_SVH
`define STREAMER_DEFINES_SVH

`default_nettype none

// Memory and stream word width
`define STREAMER_DW 32
// Byte address width
`define STREAMER_AW 32
// Load buffer depth, also the bound on reads in flight per source
`define STREAMER_LOAD_DEPTH 4
// Store buffer depth
`define STREAMER_STORE_DEPTH 2
// Arbiter ports: X, W and Z
`define STREAMER_NCH 3
// Width of the word-count field of a job
`define STREAMER_CNT_W 16

`default_nettype wire

`endif
